/* source/ibi_regf_pkg.sv */
package ibi_regf_pkg;

    //////////////////////////////////////////////////
    // Register file geometry
    //////////////////////////////////////////////////

    localparam int unsigned REGF_ADDR_W = 12;      // Default register file address width

    //////////////////////////////////////////////////
    // Per-target tables
    //////////////////////////////////////////////////

    // Dynamic address that maps to target index 0
    localparam logic [6:0]  FIRST_TGT_ADDR   = 7'h08;
    localparam int unsigned TGT_BASE_ADDR    = 200;  // First entry of target tables
    localparam int unsigned BCR_OFFSET       = 6;    // BCR slot inside one table
    localparam int unsigned TGT_STRIDE_SHIFT = 3;    // 8 entries per target

    // Fixed locations
    localparam int unsigned MDB_ADDR         = 107;  // Received mandatory data byte

endpackage

/* source/ibi_bus_pkg.sv */
package ibi_bus_pkg;

    //////////////////////////////////////////////////
    // IBI sequencing states
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        ACK       = 3'd1,   // Controller drives ACK low
        NACK      = 3'd2,   // SDA left released
        MDB       = 3'd3,   // Receiving mandatory data byte
        MDB_T_BIT = 3'd4,
        PAYLOAD   = 3'd5,   // SDR payload path owns the bus
        STOP      = 3'd6
    } ibi_state_t;

    // Serializer commands
    typedef enum logic [2:0] {
        TX_IDLE      = 3'd0,
        TX_SERIAL    = 3'd1,
        TX_STOP      = 3'd2,
        TX_DRIVE_LOW = 3'd4
    } tx_mode_t;

    // Deserializer commands
    typedef enum logic [2:0] {
        RX_ACK      = 3'd0,
        RX_DESERIAL = 3'd1
    } rx_mode_t;

    //////////////////////////////////////////////////
    // Register bit positions
    //////////////////////////////////////////////////

    localparam int unsigned CFG_CTRL_ACK_BIT = 0;   // 1 = controller ACKs the IBI
    localparam int unsigned CFG_PAYLOAD_BIT  = 1;   // 1 = read payload, 0 = terminate
    localparam int unsigned BCR_MDB_BIT      = 2;   // Target sends MDB after IBI

endpackage

/* source/ibi_regf_port.sv */
`timescale 1ns/1ps

module ibi_regf_port #(
    parameter int unsigned ADDR_W = ibi_regf_pkg::REGF_ADDR_W
) (
    input  logic              i_ibi_clk,
    input  logic              i_ibi_rst_n,
    input  logic [7:0]        i_ibi_tgt_address,
    input  logic              i_ibi_rx_mode_done,
    input  logic              i_bcr_lookup,
    input  logic              i_mdb_phase,
    input  logic              i_regf_wr_req,
    output logic [ADDR_W-1:0] o_ibi_regf_address,
    output logic              o_ibi_regf_wr_en,
    output logic              o_mdb_written
);

    import ibi_regf_pkg::*;

    logic [6:0]        tgt_index;
    logic [ADDR_W-1:0] bcr_addr;
    logic              rx_done_d1;
    logic              rx_done_d2;
    logic              wr_req_prev;

    //////////////////////////////////////////////////
    // BCR location of the requesting target
    //////////////////////////////////////////////////

    assign tgt_index = i_ibi_tgt_address[7:1] - FIRST_TGT_ADDR;  // Address bit 0 is R/W

    assign bcr_addr = ADDR_W'(TGT_BASE_ADDR + BCR_OFFSET)
                    + (ADDR_W'(tgt_index) << TGT_STRIDE_SHIFT);

    //////////////////////////////////////////////////
    // Receive-done delay
    //////////////////////////////////////////////////

    // Gives the deserializer time to settle the byte before the write
    always_ff @(posedge i_ibi_clk or negedge i_ibi_rst_n)
    begin
        if (!i_ibi_rst_n)
        begin
            rx_done_d1 <= 1'b0;
            rx_done_d2 <= 1'b0;
        end
        else
        begin
            rx_done_d1 <= i_ibi_rx_mode_done;
            rx_done_d2 <= rx_done_d1;
        end
    end

    assign o_mdb_written = rx_done_d2 & i_mdb_phase;  // Only meaningful while in MDB

    // Address register
    always_ff @(posedge i_ibi_clk or negedge i_ibi_rst_n)
    begin
        if (!i_ibi_rst_n)
            o_ibi_regf_address <= '0;
        else if (i_bcr_lookup)
            o_ibi_regf_address <= bcr_addr;
        else if (o_mdb_written)
            o_ibi_regf_address <= ADDR_W'(MDB_ADDR);  // MDB slot for the coming write
    end

    // Write strobe on the rising edge of the request
    always_ff @(posedge i_ibi_clk or negedge i_ibi_rst_n)
    begin
        if (!i_ibi_rst_n)
        begin
            wr_req_prev      <= 1'b0;
            o_ibi_regf_wr_en <= 1'b0;
        end
        else
        begin
            wr_req_prev      <= i_regf_wr_req;
            o_ibi_regf_wr_en <= i_regf_wr_req & ~wr_req_prev;
        end
    end

    // Writes only land in the MDB slot
    a_wr_en_mdb_slot : assert property (
        @(posedge i_ibi_clk) disable iff (!i_ibi_rst_n)
        o_ibi_regf_wr_en |-> (o_ibi_regf_address == ADDR_W'(MDB_ADDR))
    ) else $error("register file write strobe outside the MDB slot");

endmodule

/* source/ibi_fsm.sv */
`timescale 1ns/1ps

module ibi_fsm (
    input  logic                  i_ibi_clk,
    input  logic                  i_ibi_rst_n,
    input  logic                  i_ibi_en,
    input  logic                  i_ibi_scl,
    input  logic                  i_ibi_scl_neg_edge,
    input  logic [7:0]            i_ibi_bcr_reg,
    input  logic [7:0]            i_ibi_cfg_reg,
    input  logic                  i_ibi_ser_mode_done,
    input  logic                  i_ibi_payload_done,
    input  logic                  i_mdb_written,
    output logic                  o_ibi_pp_od,
    output logic                  o_ibi_regf_rd_en,
    output logic                  o_ibi_rx_en,
    output logic                  o_ibi_tx_en,
    output ibi_bus_pkg::rx_mode_t o_ibi_rx_mode,
    output ibi_bus_pkg::tx_mode_t o_ibi_tx_mode,
    output logic                  o_ibi_payload_en,
    output logic                  o_ibi_cnt_en,
    output logic                  o_ibi_ser_rx_tx,
    output logic                  o_ibi_done,
    output logic                  o_bcr_lookup,
    output logic                  o_mdb_phase,
    output logic                  o_regf_wr_req
);

    import ibi_bus_pkg::*;

    ibi_state_t state;
    logic       ctrl_ack;

    assign ctrl_ack = i_ibi_cfg_reg[CFG_CTRL_ACK_BIT];

    // Handshake to the register file port
    assign o_bcr_lookup = (state == IDLE) && i_ibi_en && ctrl_ack;
    assign o_mdb_phase  = (state == MDB);

    //////////////////////////////////////////////////
    // Main sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge i_ibi_clk or negedge i_ibi_rst_n)
    begin
        if (!i_ibi_rst_n)
        begin
            state            <= IDLE;
            o_ibi_pp_od      <= 1'b0;
            o_ibi_regf_rd_en <= 1'b0;
            o_ibi_rx_en      <= 1'b0;
            o_ibi_tx_en      <= 1'b0;
            o_ibi_rx_mode    <= RX_ACK;
            o_ibi_tx_mode    <= TX_IDLE;
            o_ibi_payload_en <= 1'b0;
            o_ibi_cnt_en     <= 1'b0;
            o_ibi_ser_rx_tx  <= 1'b0;
            o_ibi_done       <= 1'b0;
            o_regf_wr_req    <= 1'b0;
        end
        else
        begin
            o_ibi_done <= 1'b0;  // Pulse only
            case (state)
                IDLE:
                begin
                    o_ibi_regf_rd_en <= o_bcr_lookup;  // Fetch BCR while waiting
                    if (!i_ibi_en)
                        o_ibi_tx_en <= 1'b0;
                    else if (i_ibi_scl_neg_edge)
                    begin
                        o_ibi_pp_od <= 1'b0;  // ACK bit is open drain
                        if (ctrl_ack)
                        begin
                            state         <= ACK;
                            o_ibi_tx_en   <= 1'b1;
                            o_ibi_tx_mode <= TX_DRIVE_LOW;
                        end
                        else
                        begin
                            state       <= NACK;
                            o_ibi_tx_en <= 1'b0;  // Released SDA reads as NACK
                        end
                    end
                end

                ACK:
                begin
                    if (i_ibi_scl)  // ACK sampled on SCL high
                    begin
                        o_ibi_regf_rd_en <= 1'b0;
                        if (i_ibi_bcr_reg[BCR_MDB_BIT])
                        begin
                            state         <= MDB;
                            o_ibi_cnt_en  <= 1'b1;
                            o_ibi_rx_en   <= 1'b1;
                            o_ibi_tx_en   <= 1'b0;
                            o_ibi_pp_od   <= 1'b1;
                            o_ibi_rx_mode <= RX_DESERIAL;
                        end
                        else
                            state <= STOP;
                    end
                end

                NACK:
                begin
                    if (i_ibi_scl)
                        state <= STOP;
                end

                MDB:
                begin
                    if (i_mdb_written)
                        o_regf_wr_req <= 1'b1;
                    // T-bit starts on the next SCL low after the byte is stored
                    if (o_regf_wr_req && !i_ibi_scl)
                    begin
                        state         <= MDB_T_BIT;
                        o_regf_wr_req <= 1'b0;
                        o_ibi_rx_en   <= 1'b0;
                        o_ibi_cnt_en  <= 1'b0;
                        o_ibi_tx_mode <= TX_DRIVE_LOW;
                    end
                end

                MDB_T_BIT:
                begin
                    if (i_ibi_cfg_reg[CFG_PAYLOAD_BIT])
                    begin
                        state            <= PAYLOAD;
                        o_ibi_payload_en <= 1'b1;
                        o_ibi_ser_rx_tx  <= 1'b1;
                    end
                    else if (i_ibi_scl)
                    begin
                        state         <= STOP;
                        o_ibi_tx_en   <= 1'b1;
                        o_ibi_tx_mode <= TX_DRIVE_LOW;
                    end
                end

                PAYLOAD:
                begin
                    // SDR path counts frames and reports the end
                    if (i_ibi_payload_done)
                    begin
                        state            <= IDLE;
                        o_ibi_payload_en <= 1'b0;
                        o_ibi_ser_rx_tx  <= 1'b0;
                        o_ibi_done       <= 1'b1;
                    end
                end

                STOP:
                begin
                    if (!i_ibi_scl)
                    begin
                        o_ibi_tx_en   <= 1'b1;
                        o_ibi_tx_mode <= TX_STOP;
                    end
                    else if (i_ibi_ser_mode_done)  // SDA rose while SCL high
                    begin
                        state       <= IDLE;
                        o_ibi_done  <= 1'b1;
                        o_ibi_tx_en <= 1'b0;
                    end
                end

                default:
                    state <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Protocol checks
    //////////////////////////////////////////////////

    a_no_bus_fight : assert property (
        @(posedge i_ibi_clk) disable iff (!i_ibi_rst_n)
        !(o_ibi_tx_en && o_ibi_rx_en)
    ) else $error("serializer and deserializer enabled together");

    a_done_pulse : assert property (
        @(posedge i_ibi_clk) disable iff (!i_ibi_rst_n)
        o_ibi_done |=> !o_ibi_done
    ) else $error("ibi done held longer than one cycle");

endmodule

/* source/ibi_top.sv */
`timescale 1ns/1ps

module ibi_top #(
    parameter int unsigned ADDR_W = ibi_regf_pkg::REGF_ADDR_W
) (
    input  logic                  i_ibi_clk,
    input  logic                  i_ibi_rst_n,
    input  logic                  i_ibi_en,
    input  logic                  i_ibi_scl,
    input  logic                  i_ibi_scl_neg_edge,
    input  logic [7:0]            i_ibi_bcr_reg,
    input  logic [7:0]            i_ibi_cfg_reg,
    input  logic [7:0]            i_ibi_tgt_address,
    input  logic                  i_ibi_ser_mode_done,
    input  logic                  i_ibi_rx_mode_done,
    input  logic                  i_ibi_payload_done,
    output logic                  o_ibi_pp_od,
    output logic [ADDR_W-1:0]     o_ibi_regf_address,
    output logic                  o_ibi_regf_rd_en,
    output logic                  o_ibi_regf_wr_en,
    output logic                  o_ibi_rx_en,
    output logic                  o_ibi_tx_en,
    output ibi_bus_pkg::rx_mode_t o_ibi_rx_mode,
    output ibi_bus_pkg::tx_mode_t o_ibi_tx_mode,
    output logic                  o_ibi_payload_en,
    output logic                  o_ibi_cnt_en,
    output logic                  o_ibi_ser_rx_tx,
    output logic                  o_ibi_done
);

    // FSM to register file port
    logic bcr_lookup;
    logic mdb_phase;
    logic regf_wr_req;
    logic mdb_written;   // Back to the FSM

    ibi_fsm u_fsm (
        .i_ibi_clk           (i_ibi_clk),
        .i_ibi_rst_n         (i_ibi_rst_n),
        .i_ibi_en            (i_ibi_en),
        .i_ibi_scl           (i_ibi_scl),
        .i_ibi_scl_neg_edge  (i_ibi_scl_neg_edge),
        .i_ibi_bcr_reg       (i_ibi_bcr_reg),
        .i_ibi_cfg_reg       (i_ibi_cfg_reg),
        .i_ibi_ser_mode_done (i_ibi_ser_mode_done),
        .i_ibi_payload_done  (i_ibi_payload_done),
        .i_mdb_written       (mdb_written),
        .o_ibi_pp_od         (o_ibi_pp_od),
        .o_ibi_regf_rd_en    (o_ibi_regf_rd_en),
        .o_ibi_rx_en         (o_ibi_rx_en),
        .o_ibi_tx_en         (o_ibi_tx_en),
        .o_ibi_rx_mode       (o_ibi_rx_mode),
        .o_ibi_tx_mode       (o_ibi_tx_mode),
        .o_ibi_payload_en    (o_ibi_payload_en),
        .o_ibi_cnt_en        (o_ibi_cnt_en),
        .o_ibi_ser_rx_tx     (o_ibi_ser_rx_tx),
        .o_ibi_done          (o_ibi_done),
        .o_bcr_lookup        (bcr_lookup),
        .o_mdb_phase         (mdb_phase),
        .o_regf_wr_req       (regf_wr_req)
    );

    ibi_regf_port #(
        .ADDR_W (ADDR_W)
    ) u_regf_port (
        .i_ibi_clk          (i_ibi_clk),
        .i_ibi_rst_n        (i_ibi_rst_n),
        .i_ibi_tgt_address  (i_ibi_tgt_address),
        .i_ibi_rx_mode_done (i_ibi_rx_mode_done),
        .i_bcr_lookup       (bcr_lookup),
        .i_mdb_phase        (mdb_phase),
        .i_regf_wr_req      (regf_wr_req),
        .o_ibi_regf_address (o_ibi_regf_address),
        .o_ibi_regf_wr_en   (o_ibi_regf_wr_en),
        .o_mdb_written      (mdb_written)
    );

endmodule

/* test/ibi_tb.sv */
`timescale 1ns/1ps

module ibi_tb;

    import ibi_regf_pkg::*;
    import ibi_bus_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;  // Five tests of about 100 cycles plus margin

    logic                   i_ibi_clk;
    logic                   i_ibi_rst_n;
    logic                   i_ibi_en;
    logic                   i_ibi_scl;
    logic                   i_ibi_scl_neg_edge;
    logic [7:0]             i_ibi_bcr_reg;
    logic [7:0]             i_ibi_cfg_reg;
    logic [7:0]             i_ibi_tgt_address;
    logic                   i_ibi_ser_mode_done;
    logic                   i_ibi_rx_mode_done;
    logic                   i_ibi_payload_done;
    logic                   o_ibi_pp_od;
    logic [REGF_ADDR_W-1:0] o_ibi_regf_address;
    logic                   o_ibi_regf_rd_en;
    logic                   o_ibi_regf_wr_en;
    logic                   o_ibi_rx_en;
    logic                   o_ibi_tx_en;
    rx_mode_t               o_ibi_rx_mode;
    tx_mode_t               o_ibi_tx_mode;
    logic                   o_ibi_payload_en;
    logic                   o_ibi_cnt_en;
    logic                   o_ibi_ser_rx_tx;
    logic                   o_ibi_done;

    string       cur_test;
    logic [31:0] rnd_state;
    int          cycle_count = 0;

    ibi_top #(
        .ADDR_W (REGF_ADDR_W)
    ) i_ibi_top (
        .i_ibi_clk           (i_ibi_clk),
        .i_ibi_rst_n         (i_ibi_rst_n),
        .i_ibi_en            (i_ibi_en),
        .i_ibi_scl           (i_ibi_scl),
        .i_ibi_scl_neg_edge  (i_ibi_scl_neg_edge),
        .i_ibi_bcr_reg       (i_ibi_bcr_reg),
        .i_ibi_cfg_reg       (i_ibi_cfg_reg),
        .i_ibi_tgt_address   (i_ibi_tgt_address),
        .i_ibi_ser_mode_done (i_ibi_ser_mode_done),
        .i_ibi_rx_mode_done  (i_ibi_rx_mode_done),
        .i_ibi_payload_done  (i_ibi_payload_done),
        .o_ibi_pp_od         (o_ibi_pp_od),
        .o_ibi_regf_address  (o_ibi_regf_address),
        .o_ibi_regf_rd_en    (o_ibi_regf_rd_en),
        .o_ibi_regf_wr_en    (o_ibi_regf_wr_en),
        .o_ibi_rx_en         (o_ibi_rx_en),
        .o_ibi_tx_en         (o_ibi_tx_en),
        .o_ibi_rx_mode       (o_ibi_rx_mode),
        .o_ibi_tx_mode       (o_ibi_tx_mode),
        .o_ibi_payload_en    (o_ibi_payload_en),
        .o_ibi_cnt_en        (o_ibi_cnt_en),
        .o_ibi_ser_rx_tx     (o_ibi_ser_rx_tx),
        .o_ibi_done          (o_ibi_done)
    );

    always #4 i_ibi_clk = ~i_ibi_clk;  // 8 ns period

    // Watchdog
    always @(posedge i_ibi_clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout in %s: no response after %0d cycles", cur_test, cycle_count);
            $display("FAIL: see errors above");
            $fatal(1, "watchdog expired");
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Table base plus BCR slot, 8 entries per target
    function automatic logic [31:0] bcr_address(input logic [7:0] tgt);
        return 32'(TGT_BASE_ADDR + BCR_OFFSET) + 32'(tgt[7:1] - FIRST_TGT_ADDR) * 32'd8;
    endfunction

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("MISMATCH %s: %s expected %0h, actual %0h",
                     cur_test, what, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic tick();
        @(posedge i_ibi_clk);
        #1;                   // Drive and sample just after the edge
    endtask

    // SCL level, with a one-cycle strobe on a falling edge
    task automatic drive_scl(input logic level);
        i_ibi_scl_neg_edge = i_ibi_scl & ~level;
        i_ibi_scl          = level;
        tick();
        i_ibi_scl_neg_edge = 1'b0;
    endtask

    task automatic wait_for_done();
        while (o_ibi_done !== 1'b1)
            tick();
    endtask

    // Idle with SCL high, then raise enable and pull SCL low
    task automatic start_ibi(input logic [7:0] cfg, input logic [7:0] bcr,
                             input logic [7:0] tgt);
        i_ibi_en = 1'b0;
        drive_scl(1'b1);
        i_ibi_cfg_reg     = cfg;
        i_ibi_bcr_reg     = bcr;
        i_ibi_tgt_address = tgt;
        i_ibi_en          = 1'b1;
        tick();
        check_equal("regf_rd_en", 32'(cfg[0]), 32'(o_ibi_regf_rd_en));
        if (cfg[0])
            check_equal("BCR address", bcr_address(tgt), 32'(o_ibi_regf_address));
        drive_scl(1'b0);  // ACK or NACK slot
    endtask

    // From ACK with SCL low through the MDB byte and its write
    task automatic receive_mdb();
        int i;
        drive_scl(1'b1);
        check_equal("regf_rd_en in MDB", 32'd0, 32'(o_ibi_regf_rd_en));
        check_equal("cnt_en in MDB", 32'd1, 32'(o_ibi_cnt_en));
        check_equal("rx_en in MDB", 32'd1, 32'(o_ibi_rx_en));
        check_equal("tx_en in MDB", 32'd0, 32'(o_ibi_tx_en));
        check_equal("pp_od in MDB", 32'd1, 32'(o_ibi_pp_od));
        check_equal("rx_mode in MDB", 32'(RX_DESERIAL), 32'(o_ibi_rx_mode));
        i_ibi_rx_mode_done = 1'b1;
        tick();                           // Edge E
        i_ibi_rx_mode_done = 1'b0;
        for (i = 0; i < 3; i++)
        begin
            check_equal("regf_wr_en early", 32'd0, 32'(o_ibi_regf_wr_en));
            tick();
        end
        check_equal("regf_wr_en at E+3", 32'd1, 32'(o_ibi_regf_wr_en));
        check_equal("MDB address", 32'(MDB_ADDR), 32'(o_ibi_regf_address));
        drive_scl(1'b0);                  // T-bit
        check_equal("regf_wr_en after strobe", 32'd0, 32'(o_ibi_regf_wr_en));
        check_equal("rx_en in T-bit", 32'd0, 32'(o_ibi_rx_en));
        check_equal("cnt_en in T-bit", 32'd0, 32'(o_ibi_cnt_en));
        check_equal("tx_mode in T-bit", 32'(TX_DRIVE_LOW), 32'(o_ibi_tx_mode));
    endtask

    // From STOP with SCL high to the done pulse
    task automatic end_with_stop();
        drive_scl(1'b0);
        check_equal("tx_en in STOP", 32'd1, 32'(o_ibi_tx_en));
        check_equal("tx_mode in STOP", 32'(TX_STOP), 32'(o_ibi_tx_mode));
        i_ibi_ser_mode_done = 1'b1;
        drive_scl(1'b1);
        wait_for_done();
        check_equal("tx_en after STOP", 32'd0, 32'(o_ibi_tx_en));
        i_ibi_ser_mode_done = 1'b0;
        i_ibi_en            = 1'b0;
        tick();
        check_equal("done width", 32'd0, 32'(o_ibi_done));
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic nack_then_stop();
        cur_test = "nack_then_stop";
        start_ibi(8'h00, 8'h00, {7'h08, 1'b1});
        check_equal("tx_en on NACK", 32'd0, 32'(o_ibi_tx_en));
        drive_scl(1'b1);
        end_with_stop();
    endtask

    task automatic ack_without_mdb();
        cur_test = "ack_without_mdb";
        start_ibi(8'h01, 8'h00, {7'h0B, 1'b1});
        check_equal("tx_en on ACK", 32'd1, 32'(o_ibi_tx_en));
        check_equal("tx_mode on ACK", 32'(TX_DRIVE_LOW), 32'(o_ibi_tx_mode));
        check_equal("pp_od on ACK", 32'd0, 32'(o_ibi_pp_od));
        drive_scl(1'b1);
        check_equal("regf_rd_en after ACK", 32'd0, 32'(o_ibi_regf_rd_en));
        end_with_stop();
    endtask

    task automatic mdb_then_terminate();
        cur_test = "mdb_then_terminate";
        start_ibi(8'h01, 8'h04, {7'h09, 1'b1});
        check_equal("tx_en on ACK", 32'd1, 32'(o_ibi_tx_en));
        receive_mdb();
        drive_scl(1'b1);
        check_equal("tx_en entering STOP", 32'd1, 32'(o_ibi_tx_en));
        end_with_stop();
    endtask

    task automatic mdb_then_payload();
        cur_test = "mdb_then_payload";
        start_ibi(8'h03, 8'h04, {7'h0E, 1'b1});
        receive_mdb();
        tick();
        check_equal("payload_en", 32'd1, 32'(o_ibi_payload_en));
        check_equal("ser_rx_tx", 32'd1, 32'(o_ibi_ser_rx_tx));
        i_ibi_payload_done = 1'b1;
        wait_for_done();
        check_equal("payload_en after done", 32'd0, 32'(o_ibi_payload_en));
        check_equal("ser_rx_tx after done", 32'd0, 32'(o_ibi_ser_rx_tx));
        i_ibi_payload_done = 1'b0;
        i_ibi_en           = 1'b0;
        tick();
        check_equal("done width", 32'd0, 32'(o_ibi_done));
    endtask

    task automatic bcr_address_sweep();
        int         n;
        logic [6:0] dyn;
        cur_test = "bcr_address_sweep";
        i_ibi_en      = 1'b0;
        i_ibi_cfg_reg = 8'h01;
        drive_scl(1'b1);
        for (n = 0; n < 8; n++)
        begin
            rnd_state         = xorshift32(rnd_state);
            dyn               = 7'h08 + {4'd0, rnd_state[2:0]};
            i_ibi_tgt_address = {dyn, 1'b1};
            i_ibi_en          = 1'b1;
            tick();
            check_equal("regf_rd_en", 32'd1, 32'(o_ibi_regf_rd_en));
            check_equal("BCR address", bcr_address(i_ibi_tgt_address),
                        32'(o_ibi_regf_address));
            check_equal("regf_wr_en", 32'd0, 32'(o_ibi_regf_wr_en));
        end
        i_ibi_en = 1'b0;
        tick();
        check_equal("regf_wr_en", 32'd0, 32'(o_ibi_regf_wr_en));
    endtask

    initial
    begin
        i_ibi_clk           = 1'b0;
        i_ibi_rst_n         = 1'b0;
        i_ibi_en            = 1'b0;
        i_ibi_scl           = 1'b1;   // Bus idles high
        i_ibi_scl_neg_edge  = 1'b0;
        i_ibi_bcr_reg       = 8'h00;
        i_ibi_cfg_reg       = 8'h00;
        i_ibi_tgt_address   = 8'h00;
        i_ibi_ser_mode_done = 1'b0;
        i_ibi_rx_mode_done  = 1'b0;
        i_ibi_payload_done  = 1'b0;
        rnd_state           = 32'd24;
        cur_test            = "reset";

        repeat (3) @(posedge i_ibi_clk);
        #1;
        i_ibi_rst_n = 1'b1;
        check_equal("control outputs", 32'd0,
                    32'({o_ibi_tx_en, o_ibi_rx_en, o_ibi_regf_rd_en, o_ibi_regf_wr_en,
                         o_ibi_payload_en, o_ibi_cnt_en, o_ibi_ser_rx_tx, o_ibi_done,
                         o_ibi_pp_od}));

        nack_then_stop();
        ack_without_mdb();
        mdb_then_terminate();
        mdb_then_payload();
        bcr_address_sweep();

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* files.f */
source/ibi_regf_pkg.sv
source/ibi_bus_pkg.sv
source/ibi_regf_port.sv
source/ibi_fsm.sv
source/ibi_top.sv
test/ibi_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := ibi_tb
FILE_LIST  := files.f
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := FAIL: see errors above

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
